//--- rtl/rename_pkg.sv
package rename_pkg;

    ////////////////////////////////////////
    // Register file geometry

    // Architectural registers seen by software
    localparam int NUM_ARCH = 32;

    // Architectural register number
    typedef logic [4:0] arch_addr_t;

    // Physical register number, room for up to 64 registers
    typedef logic [5:0] phys_addr_t;

    ////////////////////////////////////////
    // In-use list record

    // Packed as {rd, new phys, previous phys}
    localparam int INUSE_W = $bits(arch_addr_t) + 2 * $bits(phys_addr_t);
    typedef logic [INUSE_W-1:0] inuse_rec_t;

    ////////////////////////////////////////
    // Control FSM
    typedef enum logic [1:0] {
        ST_INIT,
        ST_IDLE,
        ST_ACK,
        ST_RELEASE
    } ctrl_state_t;

endpackage

//--- rtl/free_list.sv
`timescale 1ns/100ps

module free_list #(
    parameter int NUM_PHYS = 64
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  rename_pkg::phys_addr_t push_data,
    input  logic                   pop,
    output rename_pkg::phys_addr_t head,
    output logic                   empty
);
    import rename_pkg::*;

    // One slot per physical register beyond the architectural set
    localparam int DEPTH = NUM_PHYS - NUM_ARCH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    ////////////////////////////////////////
    // Storage and pointers
    phys_addr_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;

    // Entry contents only written on push
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap at DEPTH, not at a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, push and pop may coincide
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////
    // Status and oldest entry
    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    ////////////////////////////////////////
    // Checks
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("free list popped while empty");

    a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("free list pushed while full");

endmodule

//--- rtl/spec_map_table.sv
`timescale 1ns/100ps

module spec_map_table (
    input  logic                   clk,
    input  logic                   rst,
    // Write port shared by init, rename and discard
    input  logic                   wr_en,
    input  rename_pkg::arch_addr_t wr_addr,
    input  rename_pkg::phys_addr_t wr_data,
    // Source read ports
    input  rename_pkg::arch_addr_t rd_addr_a,
    input  rename_pkg::arch_addr_t rd_addr_b,
    // Read port aligned with the write side
    input  rename_pkg::arch_addr_t rd_addr_w,
    output rename_pkg::phys_addr_t data_a,
    output rename_pkg::phys_addr_t data_b,
    output rename_pkg::phys_addr_t data_w
);
    import rename_pkg::*;

    ////////////////////////////////////////
    // Flip-flop array
    phys_addr_t map_q [NUM_ARCH];

    // Filled by the init sweep
    always_ff @(posedge clk) begin
        if (wr_en) begin
            map_q[wr_addr] <= wr_data;
        end
    end

    ////////////////////////////////////////
    // Combinational reads
    // Register zero reads as zero whatever the array holds
    always_comb begin
        data_a = map_q[rd_addr_a];
        if (rd_addr_a == '0) begin
            data_a = '0;
        end
    end

    always_comb begin
        data_b = map_q[rd_addr_b];
        if (rd_addr_b == '0) begin
            data_b = '0;
        end
    end

    // Used for the previous mapping of a renamed rd
    always_comb begin
        data_w = map_q[rd_addr_w];
        if (rd_addr_w == '0) begin
            data_w = '0;
        end
    end

    ////////////////////////////////////////
    // Checks
    // Register zero is never given a physical register
    a_zero_not_remapped: assert property (@(posedge clk) disable iff (rst)
        (wr_en && (wr_addr == '0)) |-> (wr_data == '0))
        else $error("register zero written with a nonzero mapping");

endmodule

//--- rtl/rename_control.sv
`timescale 1ns/100ps

module rename_control #(
    parameter int NUM_PHYS = 64
) (
    input  logic                   clk,
    input  logic                   rst,
    // Rename handshake
    input  logic                   rename_req,
    input  rename_pkg::arch_addr_t rs1_addr,
    input  rename_pkg::arch_addr_t rs2_addr,
    input  rename_pkg::arch_addr_t rd_addr,
    output logic                   rename_ack,
    output rename_pkg::phys_addr_t phys_rs1,
    output rename_pkg::phys_addr_t phys_rs2,
    output rename_pkg::phys_addr_t phys_rd,
    output rename_pkg::phys_addr_t prev_rd,
    output logic                   ready,
    // Retire pulse
    input  logic                   retire_valid,
    input  logic                   retire_discard,
    // Map table side
    output logic                   tbl_wr_en,
    output rename_pkg::arch_addr_t tbl_wr_addr,
    output rename_pkg::phys_addr_t tbl_wr_data,
    output rename_pkg::arch_addr_t tbl_rd_addr_w,
    input  rename_pkg::phys_addr_t tbl_data_a,
    input  rename_pkg::phys_addr_t tbl_data_b,
    input  rename_pkg::phys_addr_t tbl_data_w,
    // Free list side
    output logic                   fl_push,
    output rename_pkg::phys_addr_t fl_push_data,
    output logic                   fl_pop,
    input  rename_pkg::phys_addr_t fl_head,
    input  logic                   fl_empty
);
    import rename_pkg::*;

    // In-use depth matches the free list
    localparam int DEPTH = NUM_PHYS - NUM_ARCH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam phys_addr_t FREE_CNT = phys_addr_t'(DEPTH);

    ctrl_state_t      state;
    arch_addr_t       init_cnt;
    logic             retire_act;
    logic             discard_act;
    logic             do_rename;
    logic             rd_live;
    logic             iu_push;
    inuse_rec_t       iu_mem [DEPTH];
    logic [PTR_W-1:0] iu_wr_ptr;
    logic [PTR_W-1:0] iu_rd_ptr;
    logic [CNT_W-1:0] iu_count;
    arch_addr_t       rec_rd;
    phys_addr_t       rec_new;
    phys_addr_t       rec_prev;

    ////////////////////////////////////////
    // Qualifiers
    // Retires before ready are dropped
    assign retire_act  = retire_valid & ready;
    assign discard_act = retire_act & retire_discard;
    // A discard owns the write port and the rename waits a cycle
    assign do_rename   = (state == ST_IDLE) & rename_req & ~discard_act;
    assign rd_live     = (rd_addr != '0);
    assign ready       = (state != ST_INIT);
    assign rename_ack  = (state == ST_ACK);

    ////////////////////////////////////////
    // FSM and init sweep
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_INIT;
            init_cnt <= '0;
        end else begin
            case (state)
                ST_INIT: begin
                    init_cnt <= init_cnt + 1'b1;
                    if (init_cnt == arch_addr_t'(NUM_ARCH - 1)) begin
                        state <= ST_IDLE;
                    end
                end
                ST_IDLE: if (do_rename) state <= ST_ACK;
                // Held request just stretches the ack
                ST_ACK: if (!rename_req) state <= ST_RELEASE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Results captured on the request edge before the rd write lands
    always_ff @(posedge clk) begin
        if (do_rename) begin
            phys_rs1 <= tbl_data_a;
            phys_rs2 <= tbl_data_b;
            phys_rd  <= rd_live ? fl_head : '0;
            prev_rd  <= rd_live ? tbl_data_w : '0;
        end
    end

    ////////////////////////////////////////
    // In-use list in program order
    assign iu_push = do_rename & rd_live;
    assign {rec_rd, rec_new, rec_prev} = iu_mem[iu_rd_ptr];

    always_ff @(posedge clk) begin
        if (iu_push) begin
            iu_mem[iu_wr_ptr] <= {rd_addr, fl_head, tbl_data_w};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            iu_wr_ptr <= '0;
            iu_rd_ptr <= '0;
            iu_count  <= '0;
        end else begin
            if (iu_push) begin
                iu_wr_ptr <= (iu_wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : iu_wr_ptr + 1'b1;
            end
            if (retire_act) begin
                iu_rd_ptr <= (iu_rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : iu_rd_ptr + 1'b1;
            end
            if (iu_push && !retire_act) begin
                iu_count <= iu_count + 1'b1;
            end else if (!iu_push && retire_act) begin
                iu_count <= iu_count - 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Table write select
    // Discard reads back the oldest rd and a rename its own rd
    assign tbl_rd_addr_w = discard_act ? rec_rd : rd_addr;

    always_comb begin
        tbl_wr_en   = 1'b0;
        tbl_wr_addr = rd_addr;
        tbl_wr_data = fl_head;
        if (state == ST_INIT) begin
            // Identity map
            tbl_wr_en   = 1'b1;
            tbl_wr_addr = init_cnt;
            tbl_wr_data = {1'b0, init_cnt};
        end else if (discard_act) begin
            // Undo the speculative mapping
            tbl_wr_en   = 1'b1;
            tbl_wr_addr = rec_rd;
            tbl_wr_data = rec_prev;
        end else if (do_rename && rd_live) begin
            tbl_wr_en = 1'b1;
        end
    end

    ////////////////////////////////////////
    // Free list select
    assign fl_pop = do_rename & rd_live;

    always_comb begin
        fl_push      = 1'b0;
        fl_push_data = rec_prev;
        if (state == ST_INIT) begin
            // Registers NUM_ARCH up to NUM_PHYS-1 in ascending order
            fl_push      = ({1'b0, init_cnt} < FREE_CNT);
            fl_push_data = phys_addr_t'(NUM_ARCH) + {1'b0, init_cnt};
        end else if (retire_act) begin
            fl_push      = 1'b1;
            fl_push_data = retire_discard ? rec_new : rec_prev;
        end
    end

    ////////////////////////////////////////
    // Checks
    a_retire_has_record: assert property (@(posedge clk) disable iff (rst)
        retire_act |-> (iu_count != '0))
        else $error("retire with empty in-use list");

    a_pop_not_empty: assert property (@(posedge clk) disable iff (rst) fl_pop |-> !fl_empty)
        else $error("rename with no free register");

    // Requester keeps addresses steady through the ack phase
    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        (rename_ack && rename_req) |-> $stable({rs1_addr, rs2_addr, rd_addr}))
        else $error("rename addresses changed during ack");

endmodule

//--- rtl/renamer_top.sv
`timescale 1ns/100ps

module renamer_top #(
    parameter int NUM_PHYS = 64
) (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   ready,
    // Rename handshake
    input  logic                   rename_req,
    input  rename_pkg::arch_addr_t rs1_addr,
    input  rename_pkg::arch_addr_t rs2_addr,
    input  rename_pkg::arch_addr_t rd_addr,
    output logic                   rename_ack,
    output rename_pkg::phys_addr_t phys_rs1,
    output rename_pkg::phys_addr_t phys_rs2,
    output rename_pkg::phys_addr_t phys_rd,
    output rename_pkg::phys_addr_t prev_rd,
    // Retire pulse
    input  logic                   retire_valid,
    input  logic                   retire_discard
);
    import rename_pkg::*;

    ////////////////////////////////////////
    // Block interconnect
    logic       fl_push;
    logic       fl_pop;
    logic       fl_empty;
    phys_addr_t fl_push_data;
    phys_addr_t fl_head;
    logic       tbl_wr_en;
    arch_addr_t tbl_wr_addr;
    phys_addr_t tbl_wr_data;
    arch_addr_t tbl_rd_addr_w;
    phys_addr_t tbl_data_a;
    phys_addr_t tbl_data_b;
    phys_addr_t tbl_data_w;

    free_list #(.NUM_PHYS(NUM_PHYS)) i_free_list (
        .clk       (clk),
        .rst       (rst),
        .push      (fl_push),
        .push_data (fl_push_data),
        .pop       (fl_pop),
        .head      (fl_head),
        .empty     (fl_empty)
    );

    // Source ports go straight to the request addresses
    spec_map_table i_map_table (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (tbl_wr_en),
        .wr_addr   (tbl_wr_addr),
        .wr_data   (tbl_wr_data),
        .rd_addr_a (rs1_addr),
        .rd_addr_b (rs2_addr),
        .rd_addr_w (tbl_rd_addr_w),
        .data_a    (tbl_data_a),
        .data_b    (tbl_data_b),
        .data_w    (tbl_data_w)
    );

    rename_control #(.NUM_PHYS(NUM_PHYS)) i_control (
        .clk            (clk),
        .rst            (rst),
        .rename_req     (rename_req),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .rd_addr        (rd_addr),
        .rename_ack     (rename_ack),
        .phys_rs1       (phys_rs1),
        .phys_rs2       (phys_rs2),
        .phys_rd        (phys_rd),
        .prev_rd        (prev_rd),
        .ready          (ready),
        .retire_valid   (retire_valid),
        .retire_discard (retire_discard),
        .tbl_wr_en      (tbl_wr_en),
        .tbl_wr_addr    (tbl_wr_addr),
        .tbl_wr_data    (tbl_wr_data),
        .tbl_rd_addr_w  (tbl_rd_addr_w),
        .tbl_data_a     (tbl_data_a),
        .tbl_data_b     (tbl_data_b),
        .tbl_data_w     (tbl_data_w),
        .fl_push        (fl_push),
        .fl_push_data   (fl_push_data),
        .fl_pop         (fl_pop),
        .fl_head        (fl_head),
        .fl_empty       (fl_empty)
    );

endmodule

//--- dv/renamer_tb.sv
`timescale 1ns/100ps

module renamer_tb;
    import rename_pkg::*;

    ////////////////////////////////////////
    // Run setup

    // Small pool so the free list wraps within a short test
    localparam int    NUM_PHYS        = 36;
    localparam int    CLK_PERIOD      = 100;
    localparam int    RST_CYCLES      = 8;
    localparam int    CYCLES_PER_LINE = 200;
    localparam int    ACK_WAIT        = 20;
    localparam string DATA_FILE       = "dv/renamer_testdata.txt";

    logic       clk;
    logic       rst;
    logic       ready;
    logic       rename_req;
    arch_addr_t rs1_addr;
    arch_addr_t rs2_addr;
    arch_addr_t rd_addr;
    logic       rename_ack;
    phys_addr_t phys_rs1;
    phys_addr_t phys_rs2;
    phys_addr_t phys_rd;
    phys_addr_t prev_rd;
    logic       retire_valid;
    logic       retire_discard;

    int    check_cnt;
    int    mismatch_cnt;
    int    other_err_cnt;
    int    n_lines;
    bit    lines_loaded;
    string lines [$];

    renamer_top #(.NUM_PHYS(NUM_PHYS)) i_dut (
        .clk            (clk),
        .rst            (rst),
        .ready          (ready),
        .rename_req     (rename_req),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .rd_addr        (rd_addr),
        .rename_ack     (rename_ack),
        .phys_rs1       (phys_rs1),
        .phys_rs2       (phys_rs2),
        .phys_rd        (phys_rd),
        .prev_rd        (prev_rd),
        .retire_valid   (retire_valid),
        .retire_discard (retire_discard)
    );

    // 100 ns clock
    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // Helpers

    task automatic check_value(input string what, input int got, input int expected);
        check_cnt++;
        if (got != expected) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, expected);
            mismatch_cnt++;
        end
    endtask

    // Sampled on falling edges, bounded wait
    task automatic wait_ack(input logic level, output bit seen);
        int n;
        n = 0;
        while (rename_ack !== level && n < ACK_WAIT) begin
            @(negedge clk);
            n++;
        end
        seen = (rename_ack === level);
        if (!seen) begin
            $display("ERROR at %0t: rename_ack did not go to %b within %0d cycles",
                     $time, level, ACK_WAIT);
            other_err_cnt++;
        end
    endtask

    // Full four-phase handshake, optional discard on the request edge
    task automatic run_rename(input int rs1, input int rs2, input int rd, input int x_rs1,
                              input int x_rs2, input int x_rd, input int x_prev,
                              input bit with_discard);
        bit seen;
        @(negedge clk);
        rs1_addr   = arch_addr_t'(rs1);
        rs2_addr   = arch_addr_t'(rs2);
        rd_addr    = arch_addr_t'(rd);
        rename_req = 1'b1;
        if (with_discard) begin
            retire_valid   = 1'b1;
            retire_discard = 1'b1;
        end
        @(negedge clk);
        // Retire is a one-cycle pulse
        retire_valid   = 1'b0;
        retire_discard = 1'b0;
        wait_ack(1'b1, seen);
        if (seen) begin
            check_value("phys_rs1", int'(phys_rs1), x_rs1);
            check_value("phys_rs2", int'(phys_rs2), x_rs2);
            check_value("phys_rd", int'(phys_rd), x_rd);
            check_value("prev_rd", int'(prev_rd), x_prev);
        end
        rename_req = 1'b0;
        wait_ack(1'b0, seen);
        // Release state back to idle
        @(negedge clk);
    endtask

    task automatic pulse_retire(input bit discard);
        @(negedge clk);
        retire_valid   = 1'b1;
        retire_discard = discard;
        @(negedge clk);
        retire_valid   = 1'b0;
        retire_discard = 1'b0;
    endtask

    // Comment and blank lines dropped here
    task automatic load_lines();
        int    fd;
        string line;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: cannot open test data file %s", DATA_FILE);
            other_err_cnt++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0) begin
                    if (line.len() > 1 && line[0] != "#") begin
                        lines.push_back(line);
                    end
                end
            end
            $fclose(fd);
        end
        n_lines      = lines.size();
        lines_loaded = 1'b1;
    endtask

    // R = rename, T = retire, C = rename with a discard on the same edge
    task automatic run_line(input string line);
        logic [7:0] op;
        string      rest;
        int         cnt;
        int         rs1;
        int         rs2;
        int         rd;
        int         x_rs1;
        int         x_rs2;
        int         x_rd;
        int         x_prev;
        int         discard;
        op   = line[0];
        rest = line.substr(1, line.len() - 1);
        cnt  = 0;
        case (op)
            "R", "C": begin
                cnt = $sscanf(rest, "%d %d %d %d %d %d %d",
                              rs1, rs2, rd, x_rs1, x_rs2, x_rd, x_prev);
                if (cnt == 7) begin
                    run_rename(rs1, rs2, rd, x_rs1, x_rs2, x_rd, x_prev, op == "C");
                end
            end
            "T": begin
                cnt = $sscanf(rest, "%d", discard);
                if (cnt == 1) begin
                    pulse_retire(discard != 0);
                end
            end
            default: cnt = -1;
        endcase
        if ((op == "T" && cnt != 1) || (op != "T" && cnt != 7)) begin
            $display("ERROR: malformed test data line: %s", line);
            other_err_cnt++;
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    initial begin
        int n;
        clk            = 1'b0;
        rst            = 1'b1;
        rename_req     = 1'b0;
        rs1_addr       = '0;
        rs2_addr       = '0;
        rd_addr        = '0;
        retire_valid   = 1'b0;
        retire_discard = 1'b0;
        check_cnt      = 0;
        mismatch_cnt   = 0;
        other_err_cnt  = 0;
        lines_loaded   = 1'b0;
        load_lines();
        if (n_lines == 0) begin
            $display("ERROR: no test operations found in %s", DATA_FILE);
            other_err_cnt++;
        end
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        // Init sweep still running here
        check_value("ready after reset", int'(ready), 0);
        check_value("rename_ack after reset", int'(rename_ack), 0);
        n = 0;
        while (ready !== 1'b1 && n < NUM_ARCH + 4) begin
            @(negedge clk);
            n++;
        end
        if (ready !== 1'b1) begin
            $display("ERROR: ready never rose after the init sweep");
            other_err_cnt++;
        end else begin
            foreach (lines[i]) begin
                run_line(lines[i]);
            end
        end
        repeat (2) @(negedge clk);
        $display("Summary: %0d checks, %0d mismatches, %0d other errors",
                 check_cnt, mismatch_cnt, other_err_cnt);
        if (mismatch_cnt == 0 && other_err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    ////////////////////////////////////////
    // Watchdog
    // Reset plus sweep, then a budget per data line
    initial begin
        wait (lines_loaded);
        #((RST_CYCLES + NUM_ARCH + 4 + CYCLES_PER_LINE * n_lines) * CLK_PERIOD);
        $display("ERROR: watchdog expired before the test sequence finished");
        $display("Something failed");
        $finish;
    end

endmodule

//--- src.f
rtl/rename_pkg.sv
rtl/free_list.sv
rtl/spec_map_table.sv
rtl/rename_control.sv
rtl/renamer_top.sv
dv/renamer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the renamer testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=renamer_sim

verilator --binary --timing --assert -j 0 \
    -f src.f --top-module renamer_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator compilation failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Everything OK" "$LOG_FILE"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

//--- dv/renamer_testdata.txt
# R rs1 rs2 rd exp_rs1 exp_rs2 exp_rd exp_prev | T discard | C = R with discard on same edge
# Expected values assume NUM_PHYS = 36, free registers 32..35 after init
R 5 7 3 5 7 32 3
R 3 0 4 32 0 33 4
R 4 3 0 33 32 0 0
R 0 4 6 0 33 34 6
T 0
T 0
R 6 6 3 34 34 35 32
R 3 1 7 35 1 3 7
R 7 0 8 3 0 4 8
T 0
T 0
T 0
T 0
R 8 3 9 4 35 6 9
T 1
R 9 0 3 9 0 32 35
R 3 9 10 32 9 7 10
R 10 4 11 7 33 8 11
R 11 0 12 8 0 6 12
T 0
C 10 3 13 10 32 35 13
R 13 10 0 35 10 0 0
T 0
R 0 12 14 0 6 7 14
